/* txq_macros.svh */
`ifndef TXQ_MACROS_SVH
`define TXQ_MACROS_SVH

// Address and memory geometry.
`define TXQ_ADDR_W      16
`define TXQ_RAM_WORDS   256
`define TXQ_RAM_AW      8

// Transmit ring layout.
`define TXQ_RING_DESCS  16
`define TXQ_IDX_W       4
`define TXQ_RING_BASE   16'h0040  // Byte address of descriptor 0.
`define TXQ_DESC_BYTES  16

// Legacy descriptor command bits in word 2.
`define TXQ_CMD_RS      27
`define TXQ_CMD_IDE     31

// Status word fields.
`define TXQ_STAT_RS     16
`define TXQ_STAT_IDE    17

`endif

/* txq_pkg.sv */
`include "txq_macros.svh"

package txq_pkg;

	typedef logic [31:0] desc_word_t;
	typedef logic [`TXQ_ADDR_W-1:0] byte_addr_t;
	typedef logic [`TXQ_RAM_AW-1:0] ram_idx_t;
	typedef logic [`TXQ_IDX_W-1:0] ring_idx_t;
	typedef logic [1:0] beat_cnt_t;

	// IDE and RS in bits 17:16, local address in 15:0.
	typedef logic [31:0] tx_status_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_FETCH_ADDR,
		S_FETCH_DATA,
		S_PROCESS,
		S_CHECK_RS,
		S_WRITE_STROBE,
		S_WRITE_ACK,
		S_REPORT
	} tx_eng_state_t;

endpackage

/* desc_mem_if.sv */
`timescale 1ns/100ps
`include "txq_macros.svh"

interface desc_mem_if;

	txq_pkg::byte_addr_t araddr;
	logic arvalid;
	logic arready;

	txq_pkg::desc_word_t rdata;
	logic rlast;
	logic rvalid;
	logic rready;

	txq_pkg::byte_addr_t awaddr;  // Address and data form one write beat.
	txq_pkg::desc_word_t wdata;
	logic wvalid;
	logic wready;

	modport engine (
		output araddr, arvalid, rready, awaddr, wdata, wvalid,
		input  arready, rdata, rlast, rvalid, wready
	);

	modport ram (
		input  araddr, arvalid, rready, awaddr, wdata, wvalid,
		output arready, rdata, rlast, rvalid, wready
	);

endinterface

/* tx_engine.sv */
`timescale 1ns/100ps
`include "txq_macros.svh"

module tx_engine (
	input  logic                aclk,
	input  logic                aresetn,

	input  txq_pkg::byte_addr_t cmd_addr,
	input  logic                cmd_valid,
	output logic                cmd_ready,

	output txq_pkg::tx_status_t stat_data,
	output logic                stat_valid,
	input  logic                stat_ready,

	desc_mem_if.engine          mem
);

	txq_pkg::tx_eng_state_t state;
	txq_pkg::tx_eng_state_t state_next;

	txq_pkg::byte_addr_t local_addr;
	txq_pkg::beat_cnt_t fetch_cnt;
	txq_pkg::desc_word_t desc_dw [4];

	logic desc_rs;
	logic desc_ide;
	logic wvalid_q;
	logic cmd_fire;
	logic r_fire;
	logic w_fire;

	assign cmd_fire = cmd_valid && cmd_ready;
	assign r_fire = mem.rvalid && mem.rready;
	assign w_fire = mem.wvalid && mem.wready;

	assign desc_rs = desc_dw[2][`TXQ_CMD_RS];
	assign desc_ide = desc_dw[2][`TXQ_CMD_IDE];

	assign cmd_ready = (state == txq_pkg::S_IDLE);
	assign stat_valid = (state == txq_pkg::S_REPORT);

	assign mem.araddr = local_addr;
	assign mem.arvalid = (state == txq_pkg::S_FETCH_ADDR);
	assign mem.rready = (state == txq_pkg::S_FETCH_DATA);

	// Word 3 sits 12 bytes into the descriptor.
	assign mem.awaddr = local_addr + txq_pkg::byte_addr_t'(`TXQ_DESC_BYTES - 4);
	assign mem.wdata = {desc_dw[3][31:4], 3'b000, 1'b1};  // DD set, LC and EC clear.
	assign mem.wvalid = wvalid_q;

	always_comb begin
		stat_data = '0;
		stat_data[`TXQ_STAT_IDE] = desc_ide;
		stat_data[`TXQ_STAT_RS] = desc_rs;
		stat_data[`TXQ_ADDR_W-1:0] = local_addr;
	end

	always_ff @(posedge aclk) begin
		if (cmd_fire)
			local_addr <= cmd_addr;
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			fetch_cnt <= '0;
		end else if (r_fire) begin
			if (mem.rlast)
				fetch_cnt <= '0;
			else
				fetch_cnt <= fetch_cnt + 1'b1;
		end
	end

	// Beats land in order, word 0 first.
	always_ff @(posedge aclk) begin
		if (r_fire)
			desc_dw[fetch_cnt] <= mem.rdata;
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			state <= txq_pkg::S_IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			txq_pkg::S_IDLE: begin
				if (cmd_valid)
					state_next = txq_pkg::S_FETCH_ADDR;
			end
			txq_pkg::S_FETCH_ADDR: begin
				if (mem.arready)
					state_next = txq_pkg::S_FETCH_DATA;
			end
			txq_pkg::S_FETCH_DATA: begin
				if (r_fire && mem.rlast)
					state_next = txq_pkg::S_PROCESS;
			end
			txq_pkg::S_PROCESS: begin
				state_next = txq_pkg::S_CHECK_RS;
			end
			txq_pkg::S_CHECK_RS: begin
				if (desc_rs)
					state_next = txq_pkg::S_WRITE_STROBE;
				else
					state_next = txq_pkg::S_REPORT;
			end
			txq_pkg::S_WRITE_STROBE: begin
				state_next = txq_pkg::S_WRITE_ACK;
			end
			txq_pkg::S_WRITE_ACK: begin
				if (!wvalid_q || mem.wready)  // Beat taken here or earlier.
					state_next = txq_pkg::S_REPORT;
			end
			txq_pkg::S_REPORT: begin
				if (stat_ready)
					state_next = txq_pkg::S_IDLE;
			end
			default: begin
				state_next = txq_pkg::S_IDLE;
			end
		endcase
	end

	// Raised on entry to the strobe state, held until the RAM takes it.
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			wvalid_q <= 1'b0;
		else if (state == txq_pkg::S_CHECK_RS && desc_rs)
			wvalid_q <= 1'b1;
		else if (w_fire)
			wvalid_q <= 1'b0;
	end

endmodule

/* desc_ram.sv */
`timescale 1ns/100ps
`include "txq_macros.svh"

module desc_ram (
	input  logic                aclk,
	input  logic                aresetn,

	input  logic                host_we,
	input  txq_pkg::ram_idx_t   host_addr,
	input  txq_pkg::desc_word_t host_wdata,
	output txq_pkg::desc_word_t host_rdata,

	desc_mem_if.ram             mem
);

	txq_pkg::desc_word_t ram_q [`TXQ_RAM_WORDS];

	logic burst_active;
	txq_pkg::ram_idx_t burst_ptr;
	txq_pkg::beat_cnt_t burst_cnt;
	txq_pkg::ram_idx_t wr_idx;

	logic ar_fire;
	logic r_fire;
	logic w_fire;

	// Host access wins every cycle.
	assign mem.arready = !host_we && !burst_active;
	assign mem.wready = !host_we && !burst_active;
	assign mem.rvalid = burst_active && !host_we;

	assign mem.rdata = ram_q[burst_ptr];
	assign mem.rlast = (burst_cnt == 2'd3);

	assign ar_fire = mem.arvalid && mem.arready;
	assign r_fire = mem.rvalid && mem.rready;
	assign w_fire = mem.wvalid && mem.wready;

	assign wr_idx = mem.awaddr[`TXQ_RAM_AW+1:2];  // Byte to word index.

	always_ff @(posedge aclk) begin
		if (host_we)
			ram_q[host_addr] <= host_wdata;
		else if (w_fire)
			ram_q[wr_idx] <= mem.wdata;
	end

	always_ff @(posedge aclk) begin
		host_rdata <= ram_q[host_addr];
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			burst_active <= 1'b0;
			burst_ptr <= '0;
			burst_cnt <= '0;
		end else if (ar_fire) begin
			burst_active <= 1'b1;
			burst_ptr <= mem.araddr[`TXQ_RAM_AW+1:2];
			burst_cnt <= '0;
		end else if (r_fire) begin
			burst_ptr <= burst_ptr + 1'b1;  // Wraps at the top of the RAM.
			burst_cnt <= burst_cnt + 1'b1;
			if (mem.rlast)
				burst_active <= 1'b0;
		end
	end

endmodule

/* tx_ring_ctrl.sv */
`timescale 1ns/100ps
`include "txq_macros.svh"

module tx_ring_ctrl (
	input  logic                aclk,
	input  logic                aresetn,

	input  logic                tail_we,
	input  txq_pkg::ring_idx_t  tail_wdata,
	input  logic                irq_clr,

	output txq_pkg::ring_idx_t  head,
	output txq_pkg::ring_idx_t  tail,
	output logic                irq,

	output txq_pkg::byte_addr_t cmd_addr,
	output logic                cmd_valid,
	input  logic                cmd_ready,

	input  txq_pkg::tx_status_t stat_data,
	input  logic                stat_valid,
	output logic                stat_ready
);

	logic outstanding;
	logic cmd_fire;
	logic stat_fire;
	txq_pkg::ring_idx_t head_next;

	assign stat_ready = 1'b1;

	assign cmd_fire = cmd_valid && cmd_ready;
	assign stat_fire = stat_valid && stat_ready;

	assign cmd_valid = (head != tail) && !outstanding;

	assign cmd_addr = txq_pkg::byte_addr_t'(`TXQ_RING_BASE)
		+ txq_pkg::byte_addr_t'(head) * txq_pkg::byte_addr_t'(`TXQ_DESC_BYTES);

	assign head_next = (head == txq_pkg::ring_idx_t'(`TXQ_RING_DESCS - 1))
		? '0 : head + 1'b1;

	// Head and the outstanding flag move together so the next
	// command sees the advanced head.
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			head <= '0;
			outstanding <= 1'b0;
		end else if (stat_fire) begin
			head <= head_next;
			outstanding <= 1'b0;
		end else if (cmd_fire) begin
			outstanding <= 1'b1;
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			tail <= '0;
		else if (tail_we)
			tail <= tail_wdata;
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			irq <= 1'b0;
		else if (irq_clr)
			irq <= 1'b0;  // Clear beats a same-cycle set.
		else if (stat_fire && stat_data[`TXQ_STAT_IDE])
			irq <= 1'b1;
	end

endmodule

/* tx_queue_top.sv */
`timescale 1ns/100ps
`include "txq_macros.svh"

module tx_queue_top (
	input  logic                aclk,
	input  logic                aresetn,

	input  logic                host_we,
	input  txq_pkg::ram_idx_t   host_addr,
	input  txq_pkg::desc_word_t host_wdata,
	output txq_pkg::desc_word_t host_rdata,

	input  logic                tail_we,
	input  txq_pkg::ring_idx_t  tail_wdata,
	input  logic                irq_clr,

	output txq_pkg::ring_idx_t  head,
	output txq_pkg::ring_idx_t  tail,
	output logic                irq
);

	txq_pkg::byte_addr_t cmd_addr;
	logic cmd_valid;
	logic cmd_ready;

	txq_pkg::tx_status_t stat_data;
	logic stat_valid;
	logic stat_ready;

	desc_mem_if mem_bus ();

	tx_ring_ctrl u_ring_ctrl (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.tail_we    (tail_we),
		.tail_wdata (tail_wdata),
		.irq_clr    (irq_clr),
		.head       (head),
		.tail       (tail),
		.irq        (irq),
		.cmd_addr   (cmd_addr),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.stat_data  (stat_data),
		.stat_valid (stat_valid),
		.stat_ready (stat_ready)
	);

	tx_engine u_engine (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.cmd_addr   (cmd_addr),
		.cmd_valid  (cmd_valid),
		.cmd_ready  (cmd_ready),
		.stat_data  (stat_data),
		.stat_valid (stat_valid),
		.stat_ready (stat_ready),
		.mem        (mem_bus.engine)
	);

	desc_ram u_ram (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.mem        (mem_bus.ram)
	);

endmodule

/* tb_tx_queue.sv */
`timescale 1ns/100ps
`include "txq_macros.svh"

module tb_tx_queue;

	localparam int NUM_DESCS = 18;  // Descriptors processed over all tests.
	localparam int WATCHDOG_CYCLES = NUM_DESCS * 40 + 2000;
	localparam int HEAD_WAIT_CYCLES = 400;

	logic aclk;
	logic aresetn;
	logic host_we;
	txq_pkg::ram_idx_t host_addr;
	txq_pkg::desc_word_t host_wdata;
	txq_pkg::desc_word_t host_rdata;
	logic tail_we;
	txq_pkg::ring_idx_t tail_wdata;
	logic irq_clr;
	txq_pkg::ring_idx_t head;
	txq_pkg::ring_idx_t tail;
	logic irq;

	logic [31:0] lcg_state = 32'hee8e_1ea1;
	txq_pkg::desc_word_t shadow [`TXQ_RAM_WORDS];  // Expected RAM contents.
	int value_errors;
	int other_errors;
	string test_name;

	tx_queue_top UUT (
		.aclk       (aclk),
		.aresetn    (aresetn),
		.host_we    (host_we),
		.host_addr  (host_addr),
		.host_wdata (host_wdata),
		.host_rdata (host_rdata),
		.tail_we    (tail_we),
		.tail_wdata (tail_wdata),
		.irq_clr    (irq_clr),
		.head       (head),
		.tail       (tail),
		.irq        (irq)
	);

	always #50 aclk = ~aclk;

	head_step: assert property (@(posedge aclk) disable iff (!aresetn)
		(head != $past(head)) |-> (head == txq_pkg::ring_idx_t'($past(head) + 1'b1)))
	else begin
		$display("Head moved by more than one entry in test %s", test_name);
		other_errors++;
	end

	irq_cleared: assert property (@(posedge aclk) disable iff (!aresetn) irq_clr |=> !irq)
	else begin
		$display("Interrupt still set after a clear in test %s", test_name);
		other_errors++;
	end

	irq_on_advance: assert property (@(posedge aclk) disable iff (!aresetn)
		$rose(irq) |-> (head != $past(head)))
	else begin
		$display("Interrupt rose without a head advance in test %s", test_name);
		other_errors++;
	end

	function logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function logic random_bit();
		logic [31:0] r;
		r = next_random();
		return r[16];
	endfunction

	function automatic txq_pkg::desc_word_t fill_pattern(int addr);
		logic [7:0] a;
		a = addr[7:0];
		return {8'h5a ^ a, ~a, a, 8'hc3 + a};
	endfunction

	function automatic int desc_base(txq_pkg::ring_idx_t idx);
		return (int'(`TXQ_RING_BASE) + int'(idx) * `TXQ_DESC_BYTES) / 4;
	endfunction

	// DD set, LC and EC cleared when RS was requested.
	function automatic void apply_writeback(txq_pkg::ring_idx_t idx);
		int base;
		base = desc_base(idx);
		if (shadow[base + 2][`TXQ_CMD_RS])
			shadow[base + 3] = {shadow[base + 3][31:4], 4'b0001};
	endfunction

	task automatic compare_value(string what, logic [31:0] expected, logic [31:0] actual);
		assert (actual === expected)
		else begin
			$display("FAIL %s %s: expected %h, actual %h", test_name, what, expected, actual);
			value_errors++;
		end
	endtask

	// Tasks below start and end on a falling edge.
	task automatic host_write(int addr, txq_pkg::desc_word_t data);
		host_we = 1'b1;
		host_addr = txq_pkg::ram_idx_t'(addr);
		host_wdata = data;
		shadow[addr] = data;
		@(negedge aclk);
		host_we = 1'b0;
	endtask

	task automatic read_word(input int addr, output txq_pkg::desc_word_t data);
		host_addr = txq_pkg::ram_idx_t'(addr);
		@(negedge aclk);
		data = host_rdata;
	endtask

	task automatic set_tail(txq_pkg::ring_idx_t value);
		tail_we = 1'b1;
		tail_wdata = value;
		@(negedge aclk);
		tail_we = 1'b0;
	endtask

	task automatic pulse_irq_clr();
		irq_clr = 1'b1;
		@(negedge aclk);
		irq_clr = 1'b0;
	endtask

	task automatic queue_desc(txq_pkg::ring_idx_t idx, logic rs, logic ide);
		txq_pkg::desc_word_t w2;
		int base;
		base = desc_base(idx);
		w2 = next_random();
		w2[`TXQ_CMD_RS] = rs;
		w2[`TXQ_CMD_IDE] = ide;
		host_write(base, next_random());
		host_write(base + 1, next_random());
		host_write(base + 2, w2);
		host_write(base + 3, next_random());
	endtask

	task automatic wait_head(txq_pkg::ring_idx_t target);
		int n;
		n = 0;
		while (head !== target && n < HEAD_WAIT_CYCLES) begin
			@(negedge aclk);
			n++;
		end
		assert (head === target)
		else begin
			$display("Head stuck at %0d while waiting for %0d in test %s", head, target,
				test_name);
			other_errors++;
		end
	endtask

	task automatic check_desc(txq_pkg::ring_idx_t idx);
		txq_pkg::desc_word_t data;
		int base;
		base = desc_base(idx);
		for (int w = 0; w < 4; w++) begin
			read_word(base + w, data);
			compare_value($sformatf("desc %0d word %0d", idx, w), shadow[base + w], data);
		end
	endtask

	task automatic check_reset_state();
		txq_pkg::desc_word_t data;
		test_name = "reset";
		compare_value("head", 0, head);
		compare_value("tail", 0, tail);
		compare_value("irq", 0, irq);
		for (int a = 0; a < `TXQ_RAM_WORDS; a++)
			host_write(a, fill_pattern(a));
		for (int a = 0; a < `TXQ_RAM_WORDS; a++) begin
			read_word(a, data);
			compare_value($sformatf("word %0d", a), shadow[a], data);
		end
	endtask

	task automatic process_single_rs();
		test_name = "single rs";
		queue_desc(0, 1'b1, 1'b0);
		set_tail(1);
		wait_head(1);
		apply_writeback(0);
		check_desc(0);
	endtask

	task automatic process_without_rs();
		test_name = "no rs";
		queue_desc(1, 1'b0, 1'b0);
		set_tail(2);
		wait_head(2);
		check_desc(1);  // Nothing written back.
	endtask

	task automatic process_batch_with_traffic();
		txq_pkg::desc_word_t data;
		test_name = "batch";
		for (int i = 2; i < 7; i++)
			queue_desc(i, random_bit(), random_bit());
		set_tail(7);
		for (int k = 0; k < 24; k++) begin
			host_write(160 + k, next_random());  // Words outside the ring.
			@(negedge aclk);
		end
		wait_head(7);
		for (int i = 2; i < 7; i++) begin
			apply_writeback(i);
			check_desc(i);
		end
		for (int k = 0; k < 24; k++) begin
			read_word(160 + k, data);
			compare_value($sformatf("host word %0d", 160 + k), shadow[160 + k], data);
		end
		pulse_irq_clr();
		compare_value("irq after clear", 0, irq);
	endtask

	task automatic check_interrupt();
		test_name = "interrupt";
		queue_desc(7, random_bit(), 1'b1);
		set_tail(8);
		wait_head(8);
		apply_writeback(7);
		compare_value("irq set", 1, irq);
		repeat (10) @(negedge aclk);
		compare_value("irq held", 1, irq);
		pulse_irq_clr();
		compare_value("irq cleared", 0, irq);
		queue_desc(8, random_bit(), 1'b0);
		queue_desc(9, random_bit(), 1'b0);
		set_tail(10);
		wait_head(10);
		apply_writeback(8);
		apply_writeback(9);
		compare_value("irq without ide", 0, irq);
		for (int i = 7; i < 10; i++)
			check_desc(i);
	endtask

	task automatic wrap_ring();
		test_name = "ring wrap";
		set_tail(15);  // Entries 10 to 14 still hold the fill pattern.
		wait_head(15);
		for (int i = 10; i < 15; i++) begin
			apply_writeback(i);
			check_desc(i);
		end
		queue_desc(15, 1'b1, random_bit());
		queue_desc(0, 1'b1, random_bit());
		queue_desc(1, 1'b1, random_bit());
		set_tail(2);
		wait_head(2);
		repeat (20) @(negedge aclk);
		compare_value("head at rest", 2, head);
		apply_writeback(15);
		apply_writeback(0);
		apply_writeback(1);
		check_desc(15);
		check_desc(0);
		check_desc(1);
	endtask

	initial begin
		aclk = 1'b0;
		aresetn = 1'b0;
		host_we = 1'b0;
		host_addr = '0;
		host_wdata = '0;
		tail_we = 1'b0;
		tail_wdata = '0;
		irq_clr = 1'b0;
		value_errors = 0;
		other_errors = 0;
		test_name = "reset";
		repeat (8) @(negedge aclk);
		aresetn = 1'b1;
		@(negedge aclk);
		check_reset_state();
		process_single_rs();
		process_without_rs();
		process_batch_with_traffic();
		check_interrupt();
		wrap_ring();
		$display("Checks complete: %0d value errors, %0d other errors", value_errors,
			other_errors);
		if (value_errors + other_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge aclk);
		$display("Watchdog expired after %0d cycles before the tests completed",
			WATCHDOG_CYCLES);
		$display("Test failures found");
		$finish;
	end

endmodule

/* sources.f */
+incdir+.
txq_pkg.sv
desc_mem_if.sv
tx_engine.sv
desc_ram.sv
tx_ring_ctrl.sv
tx_queue_top.sv
tb_tx_queue.sv
